/* verilog/obi_pkg.sv */
/*
 * OBI instruction port types
 * Address phase request and the combined grant / response signals
 * seen by a fetch master on a read-only OBI port
 */
package obi_pkg;

  localparam int unsigned OBI_ADDR_W = 32;
  localparam int unsigned OBI_DATA_W = 32;

  // Address phase, driven by the master
  typedef struct packed {
    logic                  req;
    logic [OBI_ADDR_W-1:0] addr;
  } obi_req_t;

  // Grant plus response phase, driven by the memory
  typedef struct packed {
    logic                  gnt;
    logic                  rvalid;
    logic [OBI_DATA_W-1:0] rdata;
  } obi_rsp_t;

endpackage

/* verilog/fetch_pkg.sv */
/*
 * Fetch payload types
 * Instruction addresses, the record kept for each outstanding bus
 * request and the word handed on to decode
 */
package fetch_pkg;

  localparam int unsigned FETCH_ADDR_W = 32;
  localparam int unsigned INSTR_W      = 32;

  typedef logic [FETCH_ADDR_W-1:0] fetch_addr_t;

  // Word aligned fetch, one instruction per request
  localparam fetch_addr_t FETCH_STEP = fetch_addr_t'(4);

  // One granted request waiting for its response
  typedef struct packed {
    fetch_addr_t addr;
    logic        epoch;
  } pending_t;

  // One instruction on its way to decode
  typedef struct packed {
    fetch_addr_t        addr;
    logic [INSTR_W-1:0] instr;
  } fetch_instr_t;

endpackage

/* verilog/fetch_fifo.sv */
/*
 * Fetch FIFO
 * Circular buffer with a synchronous flush, used both for the
 * outstanding request records and for fetched instructions.
 * Push and pop may happen in the same cycle, also when full.
 */
`timescale 1ns/1ps

module fetch_fifo #(
  parameter int unsigned DEPTH = 4,
  parameter type         T     = logic [31:0],
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1,
  localparam int unsigned CNT_W = $clog2(DEPTH + 1)
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             flush_i,
  input  logic             push_i,
  input  T                 data_i,
  input  logic             pop_i,
  output T                 data_o,
  output logic             empty_o,
  output logic             full_o,
  output logic [CNT_W-1:0] count_o
);

  T                 mem_q [DEPTH];
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  // Pointer increment with wrap, DEPTH need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + PTR_W'(1);
  endfunction

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign count_o = count_q;
  assign data_o  = mem_q[rd_ptr_q];

  // A pop frees a slot in the same cycle
  assign do_pop  = pop_i && !empty_o;
  assign do_push = push_i && (!full_o || do_pop);

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + CNT_W'(1);
        2'b01:   count_q <= count_q - CNT_W'(1);
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

/* verilog/fetch_prefetch_controller.sv */
/*
 * Prefetch controller
 * Drives the OBI instruction request, keeps it stable until granted
 * and records every granted request in the pending FIFO. Owns the
 * epoch bit that marks responses from before a branch as stale.
 */
`timescale 1ns/1ps

module fetch_prefetch_controller #(
  parameter int unsigned FIFO_DEPTH      = 4,
  parameter int unsigned MAX_OUTSTANDING = 2
) (
  input  logic                                   clk_i,
  input  logic                                   rst_i,
  input  logic                                   fetch_enable_i,
  input  fetch_pkg::fetch_addr_t                 boot_addr_i,
  input  logic                                   branch_i,
  input  fetch_pkg::fetch_addr_t                 branch_addr_i,
  input  logic                                   obi_gnt_i,
  input  logic [$clog2(MAX_OUTSTANDING + 1)-1:0] pend_count_i,
  input  logic [$clog2(FIFO_DEPTH + 1)-1:0]      instr_count_i,
  output obi_pkg::obi_req_t                      obi_req_o,
  output logic                                   pend_push_o,
  output fetch_pkg::pending_t                    pend_data_o,
  output logic                                   epoch_o,
  output logic                                   flush_o
);

  import fetch_pkg::*;

  fetch_addr_t addr_q;
  fetch_addr_t redir_addr_q;
  logic        redir_valid_q;
  logic        epoch_q;
  logic        req_hold_q;
  logic        room;
  logic        req;
  logic        granted;
  logic        stalled_branch;

  // Every response must find a free slot in the instruction FIFO
  assign room = (32'(instr_count_i) + 32'(pend_count_i) < 32'(FIFO_DEPTH)) &&
                (32'(pend_count_i) < 32'(MAX_OUTSTANDING));

  // A raised request stays up until granted.
  // No new request starts in a branch cycle, the target goes out next
  assign req     = req_hold_q || (fetch_enable_i && room && !branch_i);
  assign granted = req && obi_gnt_i;

  // Branch that cannot redirect yet because the bus holds our address
  assign stalled_branch = branch_i && req && !obi_gnt_i;

  assign obi_req_o.req  = req;
  assign obi_req_o.addr = addr_q;

  // The stalled request keeps the epoch it was raised under.
  // Once a redirect is waiting the current epoch has already moved on
  assign pend_push_o       = granted;
  assign pend_data_o.addr  = addr_q;
  assign pend_data_o.epoch = redir_valid_q ? ~epoch_q : epoch_q;

  assign epoch_o = epoch_q;
  assign flush_o = branch_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      req_hold_q <= 1'b0;
    end else begin
      req_hold_q <= req && !obi_gnt_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      epoch_q <= 1'b0;
    end else if (branch_i) begin
      epoch_q <= ~epoch_q;
    end
  end

  // Fetch address and deferred redirect
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      addr_q        <= boot_addr_i;
      redir_valid_q <= 1'b0;
    end else if (stalled_branch) begin
      redir_valid_q <= 1'b1;
    end else if (branch_i) begin
      addr_q        <= branch_addr_i;
      redir_valid_q <= 1'b0;
    end else if (granted) begin
      if (redir_valid_q) begin
        addr_q <= redir_addr_q;
      end else begin
        addr_q <= addr_q + FETCH_STEP;
      end
      redir_valid_q <= 1'b0;
    end
  end

  // Latest target wins if several branches hit one stalled request
  always_ff @(posedge clk_i) begin
    if (stalled_branch) begin
      redir_addr_q <= branch_addr_i;
    end
  end

endmodule

/* verilog/fetch_response_filter.sv */
/*
 * Response filter
 * Matches each OBI read response with the oldest pending request,
 * forwards it to the instruction FIFO when its epoch is current and
 * drops it when the request was issued before a branch
 */
`timescale 1ns/1ps

module fetch_response_filter (
  input  logic                    obi_rvalid_i,
  input  logic [31:0]             obi_rdata_i,
  input  fetch_pkg::pending_t     pend_data_i,
  input  logic                    epoch_i,
  output logic                    pend_pop_o,
  output logic                    instr_push_o,
  output fetch_pkg::fetch_instr_t instr_data_o
);

  logic epoch_match;

  // Responses come back in grant order, so the FIFO head is the owner
  assign epoch_match = (pend_data_i.epoch == epoch_i);

  // Stale entries still leave the pending FIFO
  assign pend_pop_o = obi_rvalid_i;

  always_comb begin
    instr_push_o       = obi_rvalid_i && epoch_match;
    instr_data_o.addr  = pend_data_i.addr;
    instr_data_o.instr = obi_rdata_i;
  end

endmodule

/* verilog/fetch_unit.sv */
/*
 * Instruction fetch unit
 * Prefetching OBI master with a bounded number of outstanding reads.
 * Fetched words are buffered and handed to decode with valid/ready,
 * and a branch flushes the buffer and retires in-flight responses.
 */
`timescale 1ns/1ps

module fetch_unit #(
  parameter int unsigned FIFO_DEPTH      = 4,
  parameter int unsigned MAX_OUTSTANDING = 2
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    fetch_enable_i,
  input  fetch_pkg::fetch_addr_t  boot_addr_i,
  input  logic                    branch_i,
  input  fetch_pkg::fetch_addr_t  branch_addr_i,
  output obi_pkg::obi_req_t       instr_obi_req_o,
  input  obi_pkg::obi_rsp_t       instr_obi_rsp_i,
  output logic                    instr_valid_o,
  input  logic                    instr_ready_i,
  output fetch_pkg::fetch_instr_t instr_o
);

  import fetch_pkg::*;

  localparam int unsigned PEND_CNT_W  = $clog2(MAX_OUTSTANDING + 1);
  localparam int unsigned INSTR_CNT_W = $clog2(FIFO_DEPTH + 1);

  logic                   pend_push;
  logic                   pend_pop;
  pending_t               pend_wdata;
  pending_t               pend_rdata;
  logic [PEND_CNT_W-1:0]  pend_count;
  logic                   epoch;
  logic                   flush;
  logic                   instr_push;
  logic                   instr_pop;
  logic                   instr_empty;
  fetch_instr_t           instr_wdata;
  logic [INSTR_CNT_W-1:0] instr_count;

  // Decode handshake on the instruction FIFO head
  assign instr_valid_o = ~instr_empty;
  assign instr_pop     = instr_valid_o & instr_ready_i;

  fetch_prefetch_controller #(
    .FIFO_DEPTH      (FIFO_DEPTH),
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) i_prefetch_controller (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .fetch_enable_i (fetch_enable_i),
    .boot_addr_i    (boot_addr_i),
    .branch_i       (branch_i),
    .branch_addr_i  (branch_addr_i),
    .obi_gnt_i      (instr_obi_rsp_i.gnt),
    .pend_count_i   (pend_count),
    .instr_count_i  (instr_count),
    .obi_req_o      (instr_obi_req_o),
    .pend_push_o    (pend_push),
    .pend_data_o    (pend_wdata),
    .epoch_o        (epoch),
    .flush_o        (flush)
  );

  // Stale records must still be popped, so this one never flushes
  fetch_fifo #(
    .DEPTH (MAX_OUTSTANDING),
    .T     (pending_t)
  ) i_pend_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .flush_i (1'b0),
    .push_i  (pend_push),
    .data_i  (pend_wdata),
    .pop_i   (pend_pop),
    .data_o  (pend_rdata),
    .empty_o (),
    .full_o  (),
    .count_o (pend_count)
  );

  fetch_response_filter i_response_filter (
    .obi_rvalid_i (instr_obi_rsp_i.rvalid),
    .obi_rdata_i  (instr_obi_rsp_i.rdata),
    .pend_data_i  (pend_rdata),
    .epoch_i      (epoch),
    .pend_pop_o   (pend_pop),
    .instr_push_o (instr_push),
    .instr_data_o (instr_wdata)
  );

  fetch_fifo #(
    .DEPTH (FIFO_DEPTH),
    .T     (fetch_instr_t)
  ) i_instr_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .flush_i (flush),
    .push_i  (instr_push),
    .data_i  (instr_wdata),
    .pop_i   (instr_pop),
    .data_o  (instr_o),
    .empty_o (instr_empty),
    .full_o  (),
    .count_o (instr_count)
  );

endmodule

/* testbench/fetch_unit_checker.sv */
/*
 * Fetch unit protocol checker
 * Concurrent assertions on the OBI instruction port and on the
 * decode handshake, bound into the fetch unit
 */
`timescale 1ns/1ps

module fetch_unit_checker (
  input logic                    clk_i,
  input logic                    rst_i,
  input logic                    branch_i,
  input obi_pkg::obi_req_t       obi_req_i,
  input obi_pkg::obi_rsp_t       obi_rsp_i,
  input logic                    instr_valid_i,
  input logic                    instr_ready_i,
  input fetch_pkg::fetch_instr_t instr_i
);

  // Requests granted on the port and not yet answered
  logic [7:0] outstanding_q;

  // Number of failed assertions
  int unsigned assert_errors = 0;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      outstanding_q <= '0;
    end else begin
      outstanding_q <= outstanding_q + 8'(obi_req_i.req && obi_rsp_i.gnt) - 8'(obi_rsp_i.rvalid);
    end
  end

  a_addr_stable: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (obi_req_i.req && !obi_rsp_i.gnt) |=> (obi_req_i.req && $stable(obi_req_i.addr))
  ) else begin
    $error("OBI request dropped or address changed before grant");
    assert_errors++;
  end

  a_rvalid_owned: assert property (
    @(posedge clk_i) disable iff (rst_i)
    obi_rsp_i.rvalid |-> (outstanding_q != '0)
  ) else begin
    $error("OBI rvalid with no outstanding request");
    assert_errors++;
  end

  // A branch flushes the buffer, so the head may change then
  a_instr_stable: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (instr_valid_i && !instr_ready_i && !branch_i) |=> (instr_valid_i && $stable(instr_i))
  ) else begin
    $error("decode output changed while stalled");
    assert_errors++;
  end

endmodule

/* testbench/fetch_unit_tb.sv */
/*
 * Fetch unit testbench
 * OBI memory model with random grant and response delays, a scoreboard
 * on the request and decode sides and directed tests for boot order,
 * back-pressure, outstanding limit, branches and fetch disable
 */
`timescale 1ns/1ps

module fetch_unit_tb;

  import obi_pkg::*;
  import fetch_pkg::*;

  localparam int unsigned FIFO_DEPTH      = 4;
  localparam int unsigned MAX_OUTSTANDING = 2;
  localparam fetch_addr_t BOOT_ADDR       = 32'h0000_1000;
  localparam int unsigned TIMEOUT_CYCLES  = 2 * (8 + 150 + 400 + 150 + 150 + 150 + 100);

  logic         clk_i = 1'b0;
  logic         rst_i;
  logic         fetch_enable_i;
  fetch_addr_t  boot_addr_i;
  logic         branch_i;
  fetch_addr_t  branch_addr_i;
  obi_req_t     instr_obi_req_o;
  obi_rsp_t     instr_obi_rsp_i;
  logic         instr_valid_o;
  logic         instr_ready_i;
  fetch_instr_t instr_o;

  // Memory model, responses kept in grant order
  logic [31:0]  lfsr_q = 32'd97978;
  logic         hold_gnt = 1'b0;
  int unsigned  gnt_wait_q = 0;
  int unsigned  last_due = 0;
  int unsigned  rsp_due_q[$];
  fetch_addr_t  rsp_addr_q[$];
  logic         rsp_stale_q[$];

  // Scoreboard
  fetch_addr_t  exp_instr_addr;
  fetch_addr_t  exp_req_addr;
  fetch_addr_t  redir_target;
  logic         redir_pending = 1'b0;
  logic         stall_stale = 1'b0;
  logic         prev_stall = 1'b0;
  int unsigned  queued = 0;
  int unsigned  delivered = 0;
  int unsigned  cycle_cnt = 0;
  int unsigned  mismatches = 0;
  int unsigned  failures = 0;

  fetch_unit #(
    .FIFO_DEPTH      (FIFO_DEPTH),
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) i_fetch_unit (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .fetch_enable_i  (fetch_enable_i),
    .boot_addr_i     (boot_addr_i),
    .branch_i        (branch_i),
    .branch_addr_i   (branch_addr_i),
    .instr_obi_req_o (instr_obi_req_o),
    .instr_obi_rsp_i (instr_obi_rsp_i),
    .instr_valid_o   (instr_valid_o),
    .instr_ready_i   (instr_ready_i),
    .instr_o         (instr_o)
  );

  bind fetch_unit fetch_unit_checker i_checker (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .branch_i      (branch_i),
    .obi_req_i     (instr_obi_req_o),
    .obi_rsp_i     (instr_obi_rsp_i),
    .instr_valid_i (instr_valid_o),
    .instr_ready_i (instr_ready_i),
    .instr_i       (instr_o)
  );

  always #2 clk_i = ~clk_i;

  // Galois LFSR, taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic int unsigned draw_bits(input int unsigned n);
    int unsigned v;
    v = 0;
    for (int unsigned i = 0; i < n; i++) begin
      v = (v << 1) | 32'(lfsr_q[0]);
      lfsr_q = lfsr_step(lfsr_q);
    end
    return v;
  endfunction

  // Memory content, the address with its upper half inverted
  function automatic logic [31:0] mem_word(input fetch_addr_t addr);
    return {~addr[31:16], addr[15:0]};
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
    $display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
    mismatches++;
  endtask

  task automatic report_failure(input string what);
    $display("error at %0t: %s", $time, what);
    failures++;
  endtask

  task automatic print_summary();
    $display("checked %0d instructions, %0d mismatches, %0d other errors, %0d assertion errors",
             delivered, mismatches, failures, i_fetch_unit.i_checker.assert_errors);
  endtask

  // Grant and response phase, driven on the falling edge
  always @(negedge clk_i) begin
    instr_obi_rsp_i.gnt = !hold_gnt && (gnt_wait_q == 0);
    if (rsp_due_q.size() != 0 && rsp_due_q[0] <= cycle_cnt) begin
      instr_obi_rsp_i.rvalid = 1'b1;
      instr_obi_rsp_i.rdata  = mem_word(rsp_addr_q[0]);
    end else begin
      instr_obi_rsp_i.rvalid = 1'b0;
      instr_obi_rsp_i.rdata  = '0;
    end
  end

  always @(posedge clk_i) begin : monitor
    int unsigned due;
    cycle_cnt++;
    if (rst_i) begin
      exp_instr_addr = boot_addr_i;
      exp_req_addr   = boot_addr_i;
      gnt_wait_q     = 0;
    end else begin
      if (instr_valid_o && instr_ready_i) begin
        if (instr_o.addr !== exp_instr_addr) begin
          report_mismatch("instr_o.addr", exp_instr_addr, instr_o.addr);
        end
        if (instr_o.instr !== mem_word(exp_instr_addr)) begin
          report_mismatch("instr_o.instr", mem_word(exp_instr_addr), instr_o.instr);
        end
        if (queued == 0) begin
          report_failure("decode got an instruction that was never kept");
        end else begin
          queued--;
        end
        exp_instr_addr = exp_instr_addr + 32'd4;
        delivered++;
      end
      if (instr_obi_rsp_i.rvalid) begin
        if (!rsp_stale_q[0]) begin
          queued++;
        end
        void'(rsp_due_q.pop_front());
        void'(rsp_addr_q.pop_front());
        void'(rsp_stale_q.pop_front());
      end
      if (instr_obi_req_o.req && !prev_stall && !fetch_enable_i) begin
        report_failure("new request raised with fetch disabled");
      end
      if (instr_obi_req_o.req && instr_obi_rsp_i.gnt) begin
        if (instr_obi_req_o.addr !== exp_req_addr) begin
          report_mismatch("instr_obi_req_o.addr", exp_req_addr, instr_obi_req_o.addr);
        end
        due = cycle_cnt + draw_bits(2);
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        rsp_due_q.push_back(due);
        rsp_addr_q.push_back(instr_obi_req_o.addr);
        rsp_stale_q.push_back(stall_stale);
        stall_stale   = 1'b0;
        exp_req_addr  = redir_pending ? redir_target : exp_req_addr + 32'd4;
        redir_pending = 1'b0;
        gnt_wait_q    = draw_bits(2);
      end else if (instr_obi_req_o.req && gnt_wait_q != 0) begin
        gnt_wait_q--;
      end
      prev_stall = instr_obi_req_o.req && !instr_obi_rsp_i.gnt;
      if (branch_i) begin
        foreach (rsp_stale_q[i]) begin
          rsp_stale_q[i] = 1'b1;
        end
        queued         = 0;
        exp_instr_addr = branch_addr_i;
        if (instr_obi_req_o.req && !instr_obi_rsp_i.gnt) begin
          redir_pending = 1'b1;
          redir_target  = branch_addr_i;
          stall_stale   = 1'b1;
        end else begin
          exp_req_addr  = branch_addr_i;
          redir_pending = 1'b0;
        end
      end
      if (rsp_addr_q.size() > MAX_OUTSTANDING) begin
        report_failure("more requests outstanding than allowed");
      end
      if (rsp_addr_q.size() + queued > FIFO_DEPTH) begin
        report_failure("outstanding plus buffered instructions exceed FIFO depth");
      end
    end
  end

  task automatic wait_delivered(input int unsigned n);
    int unsigned target;
    target = delivered + n;
    while (delivered < target) begin
      @(negedge clk_i);
    end
  endtask

  task automatic test_boot_order();
    @(negedge clk_i);
    if (instr_obi_req_o.req !== 1'b0) begin
      report_failure("request raised right after reset");
    end
    if (instr_valid_o !== 1'b0) begin
      report_failure("instruction valid right after reset");
    end
    fetch_enable_i = 1'b1;
    instr_ready_i  = 1'b1;
    wait_delivered(12);
  endtask

  task automatic test_backpressure();
    int unsigned target;
    target = delivered + 24;
    while (delivered < target) begin
      instr_ready_i = 1'b0;
      repeat (draw_bits(3)) @(negedge clk_i);
      instr_ready_i = 1'b1;
      repeat (1 + draw_bits(2)) @(negedge clk_i);
    end
  endtask

  task automatic test_outstanding_limit();
    int unsigned waited;
    waited        = 0;
    instr_ready_i = 1'b0;
    while (queued < FIFO_DEPTH && waited < 30) begin
      @(negedge clk_i);
      waited++;
    end
    if (queued != FIFO_DEPTH || !instr_valid_o) begin
      report_failure("instruction FIFO did not fill under back-pressure");
    end
    if (instr_obi_req_o.req) begin
      report_failure("request raised with the instruction FIFO full");
    end
    instr_ready_i = 1'b1;
    wait_delivered(8);
  endtask

  task automatic test_branch_in_flight();
    // With the limit reached one response is still out after the branch edge
    while (rsp_addr_q.size() < MAX_OUTSTANDING) begin
      @(negedge clk_i);
    end
    branch_i      = 1'b1;
    branch_addr_i = 32'h0000_8000;
    @(negedge clk_i);
    branch_i = 1'b0;
    wait_delivered(8);
  endtask

  task automatic test_branch_stalled();
    fetch_addr_t stalled;
    @(posedge clk_i);
    hold_gnt = 1'b1;
    @(negedge clk_i);
    while (!instr_obi_req_o.req) begin
      @(negedge clk_i);
    end
    // One more cycle so the request is held, not freshly raised
    @(negedge clk_i);
    stalled       = instr_obi_req_o.addr;
    branch_i      = 1'b1;
    branch_addr_i = 32'h0002_0000;
    @(negedge clk_i);
    branch_i = 1'b0;
    repeat (3) begin
      if (!instr_obi_req_o.req) begin
        report_failure("stalled request dropped before grant");
      end else if (instr_obi_req_o.addr !== stalled) begin
        report_mismatch("instr_obi_req_o.addr", stalled, instr_obi_req_o.addr);
      end
      @(negedge clk_i);
    end
    @(posedge clk_i);
    hold_gnt = 1'b0;
    wait_delivered(8);
  endtask

  task automatic test_fetch_disable();
    @(negedge clk_i);
    fetch_enable_i = 1'b0;
    while (rsp_addr_q.size() != 0 || queued != 0) begin
      @(negedge clk_i);
    end
    repeat (10) @(negedge clk_i);
    if (instr_valid_o || rsp_addr_q.size() != 0) begin
      report_failure("responses did not drain with fetch disabled");
    end
  endtask

  initial begin
    rst_i           = 1'b1;
    fetch_enable_i  = 1'b0;
    boot_addr_i     = BOOT_ADDR;
    branch_i        = 1'b0;
    branch_addr_i   = '0;
    instr_ready_i   = 1'b0;
    instr_obi_rsp_i = '0;
    repeat (8) @(negedge clk_i);
    rst_i = 1'b0;
    test_boot_order();
    test_backpressure();
    test_outstanding_limit();
    test_branch_in_flight();
    test_branch_stalled();
    test_fetch_disable();
    @(negedge clk_i);
    print_summary();
    if (mismatches + failures + i_fetch_unit.i_checker.assert_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(negedge clk_i);
    end
    report_failure("timeout, tests did not finish in the cycle limit");
    print_summary();
    $display("** FAIL **");
    $finish;
  end

endmodule

/* fetch_unit.f */
verilog/obi_pkg.sv
verilog/fetch_pkg.sv
verilog/fetch_fifo.sv
verilog/fetch_prefetch_controller.sv
verilog/fetch_response_filter.sv
verilog/fetch_unit.sv
testbench/fetch_unit_checker.sv
testbench/fetch_unit_tb.sv

/* Makefile */
# Verilator build and run for the fetch unit testbench

VERILATOR ?= verilator
TOP       ?= fetch_unit_tb
FILELIST  ?= fetch_unit.f
BUILD_DIR ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --timing --assert --timescale 1ns/1ps

SIM       := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))
PASS_TEXT := ** PASS **

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

# The run passes only if the simulation prints the pass line
run: $(SIM)
	@out="$$(./$(SIM))"; status=$$?; echo "$$out"; \
	if [ $$status -eq 0 ] && echo "$$out" | grep -qF '$(PASS_TEXT)'; then \
		exit 0; \
	else \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
